//--- Makefile
# Verilator build and run of the control hub testbench

TOP = kiwi_ctrl_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --timescale 1ns/1ps -f sim.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q '\*\* PASS \*\*'

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- dv/kiwi_ctrl_tb.sv
/* testbench for the receiver control hub
   drives the cpu bus, tracks expected state and checks pins and read data */
`timescale 1ns/1ps
`include "kiwi_defines.svh"

module kiwi_ctrl_tb
    import kiwi_pkg::*;
();

    localparam int win_bits = `KIWI_OVFL_WIN_BITS;
    localparam int win_len  = 1 << win_bits;
    // well above the stimulus length of all tests together
    localparam int timeout_cycles = 6000;

    logic  cpu_clk;
    logic  rx_orst;
    op_t   op;
    tos_t  tos;
    logic  wr_reg;
    logic  wr_evt;
    logic  rd_reg;
    logic  adc_ovfl;
    logic  host_srq;
    word_t host_dout;
    word_t par;
    logic  ser;
    logic  adc_clken;
    logic  ewp;
    logic  cmd_ready;
    logic  snd_intr;

    // random source and background stimulus controls
    int    seed = 76730;
    bit    ovfl_on;
    bit    srq_on;
    int    ovfl_dens;

    // expected state updated on each rising edge
    int                  cyc_cnt = 0;
    logic [win_bits-1:0] win_pos;
    logic [win_len-1:0]  win_pat;
    logic [win_bits:0]   mask_ref;
    logic                pulse_ref;
    logic                sticky_ref;
    logic                srq_ref;
    logic                ser_ref;

    // sequence variables
    int    i;
    int    k;
    int    gap;
    int    idle;
    int    clr_mark;
    tos_t  val;
    word_t dval;
    op_t   oval;
    logic  strobe;
    logic  kind;

    kiwi_ctrl_top dut (.*);

    always #20 cpu_clk = ~cpu_clk;

    //////////////////////////////////////////////////////////////////////
    // reference functions
    //////////////////////////////////////////////////////////////////////

    // masked overflow count of one window without its last cycle
    function automatic logic window_ovfl(input logic [win_len-1:0] pat,
                                         input logic [win_bits:0] mask);
        int cnt;
        int n;
        cnt = 0;
        for (n = 0; n < win_len - 1; n++)
        begin
            if (pat[n])
                cnt = cnt + 1;
        end
        return ((cnt[win_bits:0] & mask) != '0);
    endfunction

    // status fields placed bit by bit, bits 7 to 4 stay zero
    function automatic word_t status_word(input logic ovfl, input logic srq);
        word_t st;
        st       = '0;
        st[15]   = ovfl;
        st[14]   = srq;
        st[13:8] = `KIWI_FPGA_VER;
        st[3:0]  = `KIWI_FPGA_ID;
        return st;
    endfunction

    // byte k of ctr1 high and byte k of ctr0 low
    function automatic word_t ctr_read_word(input ctr_t c1, input ctr_t c0, input int k);
        return {c1[8*k +: 8], c0[8*k +: 8]};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // background stimulus and expected state
    //////////////////////////////////////////////////////////////////////

    // random overflow line and host requests with a per window density
    always @(posedge cpu_clk)
    begin
        adc_ovfl <= ovfl_on && (($random(seed) & 63) < ovfl_dens);
        host_srq <= srq_on && (($random(seed) & 7) == 0);
    end

    always @(posedge cpu_clk)
    begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= timeout_cycles)
        begin
            $display("run timed out after %0d cycles without finishing", cyc_cnt);
            $display("** FAIL **");
            $fatal(1, "timeout");
        end
        if (rx_orst)
        begin
            win_pos    <= '0;
            mask_ref   <= '0;
            pulse_ref  <= 1'b0;
            sticky_ref <= 1'b0;
            srq_ref    <= 1'b0;
            ser_ref    <= 1'b0;
        end
        else
        begin
            if (wr_reg && op[`KIWI_OP_SET_CNT_MASK])
                mask_ref <= tos[win_bits:0];
            // last window cycle evaluates and the others record the line
            if (win_pos == {win_bits{1'b1}})
                pulse_ref <= window_ovfl(win_pat, mask_ref);
            else
            begin
                win_pat[win_pos] <= adc_ovfl;
                pulse_ref        <= 1'b0;
            end
            win_pos <= win_pos + 1'b1;
            // set wins over a clear in the same cycle
            if (wr_evt && op[`KIWI_OP_OVFL_CLR])
                sticky_ref <= pulse_ref;
            else
                sticky_ref <= sticky_ref | pulse_ref;
            // request in the read cycle counts toward the next read
            if (rd_reg && op[`KIWI_OP_GET_SRQ])
            begin
                ser_ref <= srq_ref;
                srq_ref <= host_srq;
            end
            else
                srq_ref <= srq_ref | host_srq;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
        begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            $display("** FAIL **");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("FAIL %s expected %b actual %b", name, exp, act);
            $display("** FAIL **");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // pin order osc_en, eeprom_wp, cmd_ready, snd_intr
    task automatic check_ctrl(input string name, input ctrl_t exp);
        logic [3:0] exp_pins;
        logic [3:0] act_pins;
        exp_pins = {exp.osc_en, exp.eeprom_wp, exp.cmd_ready, exp.snd_intr};
        act_pins = {adc_clken, ewp, cmd_ready, snd_intr};
        if (act_pins !== exp_pins)
        begin
            $display("FAIL %s expected %b actual %b", name, exp_pins, act_pins);
            $display("** FAIL **");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // bus tasks
    //////////////////////////////////////////////////////////////////////

    // drop all strobes on the next edge
    task automatic end_cmd();
        @(posedge cpu_clk);
        op     <= '0;
        wr_reg <= 1'b0;
        wr_evt <= 1'b0;
        rd_reg <= 1'b0;
    endtask

    task automatic bus_write(input int bit_pos, input tos_t data);
        @(posedge cpu_clk);
        op     <= op_t'(1) << bit_pos;
        tos    <= data;
        wr_reg <= 1'b1;
        end_cmd();
    endtask

    task automatic bus_event(input int bit_pos);
        @(posedge cpu_clk);
        op     <= op_t'(1) << bit_pos;
        wr_evt <= 1'b1;
        end_cmd();
    endtask

    // returns in the strobe cycle so par can be sampled
    task automatic read_begin(input int bit_pos);
        @(posedge cpu_clk);
        op     <= op_t'(1) << bit_pos;
        rd_reg <= 1'b1;
        @(negedge cpu_clk);
    endtask

    task automatic wait_win_pos(input int pos);
        do
        begin
            @(negedge cpu_clk);
        end
        while (win_pos != pos[win_bits-1:0]);
    endtask

    task automatic read_status(input string name);
        read_begin(`KIWI_OP_GET_STATUS);
        check_word(name, status_word(sticky_ref, srq_ref), par);
        end_cmd();
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        cpu_clk   = 1'b0;
        rx_orst   = 1'b1;
        op        = '0;
        tos       = '0;
        wr_reg    = 1'b0;
        wr_evt    = 1'b0;
        rd_reg    = 1'b0;
        adc_ovfl  = 1'b0;
        host_srq  = 1'b0;
        host_dout = '0;
        ovfl_on   = 1'b0;
        srq_on    = 1'b0;
        ovfl_dens = 0;
        repeat (16) @(posedge cpu_clk);
        rx_orst <= 1'b0;

        // reset values and then control writes one cycle later on the pins
        @(negedge cpu_clk);
        check_ctrl("reset pins", ctrl_t'(16'h0000));
        check_bit("reset ser", 1'b0, ser);
        read_begin(`KIWI_OP_GET_STATUS);
        check_bit("reset status ovfl", 1'b0, par[15]);
        end_cmd();
        for (i = 0; i < 12; i++)
        begin
            @(negedge cpu_clk);
            val = $random(seed);
            bus_write(`KIWI_OP_SET_CTRL, val);
            @(negedge cpu_clk);
            check_ctrl("ctrl write", ctrl_t'(val[15:0]));
        end

        // random windows and masks with status read at boundary plus 3
        @(negedge cpu_clk);
        ovfl_on = 1'b1;
        for (i = 0; i < 8; i++)
        begin
            @(negedge cpu_clk);
            ovfl_dens = $random(seed) & 15;
            bus_write(`KIWI_OP_SET_CNT_MASK, $random(seed));
            wait_win_pos(2);
            read_status("ovfl window status");
            if ((i % 2) == 1)
            begin
                bus_event(`KIWI_OP_OVFL_CLR);
                read_status("ovfl clear status");
            end
        end

        // force a set, quiet the line, then clear
        @(negedge cpu_clk);
        ovfl_dens = 40;
        bus_write(`KIWI_OP_SET_CNT_MASK, 32'h0000_007f);
        wait_win_pos(2);
        wait_win_pos(2);
        read_begin(`KIWI_OP_GET_STATUS);
        check_bit("ovfl sticky set", 1'b1, par[15]);
        end_cmd();
        @(negedge cpu_clk);
        ovfl_on = 1'b0;
        wait_win_pos(2);
        wait_win_pos(2);
        bus_event(`KIWI_OP_OVFL_CLR);
        read_begin(`KIWI_OP_GET_STATUS);
        check_bit("ovfl sticky cleared", 1'b0, par[15]);
        end_cmd();

        // host requests against serial reads and status bit 14
        @(negedge cpu_clk);
        srq_on = 1'b1;
        for (i = 0; i < 40; i++)
        begin
            @(negedge cpu_clk);
            gap  = $random(seed) & 7;
            kind = ($random(seed) & 1) != 0;
            repeat (gap) @(negedge cpu_clk);
            if (kind)
            begin
                read_begin(`KIWI_OP_GET_SRQ);
                end_cmd();
                @(negedge cpu_clk);
                check_bit("srq ser", ser_ref, ser);
            end
            else
            begin
                read_begin(`KIWI_OP_GET_STATUS);
                check_bit("srq pending", srq_ref, par[14]);
                end_cmd();
            end
        end
        @(negedge cpu_clk);
        srq_on = 1'b0;

        // clear, gated count of idle + 2 cycles, then all four byte reads
        for (i = 0; i < 3; i++)
        begin
            @(negedge cpu_clk);
            idle = $random(seed) & 255;
            bus_event(`KIWI_OP_CPU_CTR_CLR);
            @(negedge cpu_clk);
            clr_mark = cyc_cnt;
            bus_event(`KIWI_OP_CPU_CTR_ENA);
            repeat (idle) @(posedge cpu_clk);
            bus_event(`KIWI_OP_CPU_CTR_DIS);
            for (k = 0; k < 4; k++)
            begin
                read_begin(`KIWI_OP_GET_CPU_CTR0 + k);
                check_word($sformatf("ctr byte %0d", k),
                           ctr_read_word(ctr_t'(idle + 2), ctr_t'(cyc_cnt - clr_mark), k),
                           par);
                end_cmd();
            end
        end

        // host data passes through when no get bit is active
        for (i = 0; i < 24; i++)
        begin
            @(negedge cpu_clk);
            dval   = word_t'($random(seed));
            oval   = op_t'($random(seed)) & 16'hff03;
            strobe = ($random(seed) & 1) != 0;
            @(posedge cpu_clk);
            host_dout <= dval;
            op        <= oval;
            rd_reg    <= strobe;
            @(negedge cpu_clk);
            check_word("host data", dval, par);
        end
        end_cmd();

        @(negedge cpu_clk);
        $display("** PASS **");
        $finish;
    end

endmodule

//--- rtl/adc_ovfl_monitor.sv
/* adc overflow monitor
   counts overflow cycles per fixed window, masks the count, keeps a sticky flag */
`timescale 1ns/1ps
`include "kiwi_defines.svh"

module adc_ovfl_monitor
    import kiwi_pkg::*;
#(
    parameter int win_bits = `KIWI_OVFL_WIN_BITS
)
(
    input  logic cpu_clk,
    input  logic rx_orst,
    // cpu register bus
    input  op_t  op,
    input  tos_t tos,
    input  logic wr_reg,
    input  logic wr_evt,
    // overflow line, already on cpu_clk
    input  logic adc_ovfl,
    // sticky overflow flag
    output logic overflow
);

    localparam logic [win_bits-1:0] win_one = {{(win_bits-1){1'b0}}, 1'b1};

    // bus decode
    logic                set_mask;
    logic                ovfl_clr;
    // window position and per-window overflow count
    logic [win_bits-1:0] win_ctr;
    logic [win_bits:0]   ovfl_cnt;
    logic [win_bits:0]   cnt_mask;
    logic                win_last;
    // one-cycle pulse at the end of a flagged window
    logic                ovfl_pulse;

    assign set_mask = wr_reg & op[`KIWI_OP_SET_CNT_MASK];
    assign ovfl_clr = wr_evt & op[`KIWI_OP_OVFL_CLR];
    assign win_last = (win_ctr == {win_bits{1'b1}});

    // mask selects which count bits count as an overflow
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
            cnt_mask <= '0;
        else if (set_mask)
            cnt_mask <= tos[win_bits:0];
    end

    //////////////////////////////////////////////////////////////////////
    // window counter and overflow count
    //////////////////////////////////////////////////////////////////////

    // last cycle of the window is not counted, it evaluates and restarts
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
        begin
            win_ctr    <= '0;
            ovfl_cnt   <= '0;
            ovfl_pulse <= 1'b0;
        end
        else if (win_last)
        begin
            win_ctr    <= '0;
            ovfl_cnt   <= '0;
            ovfl_pulse <= ((ovfl_cnt & cnt_mask) != '0);
        end
        else
        begin
            win_ctr    <= win_ctr + win_one;
            ovfl_cnt   <= ovfl_cnt + {{win_bits{1'b0}}, adc_ovfl};
            ovfl_pulse <= 1'b0;
        end
    end

    // sticky flag, a pulse in the clear cycle still sets it
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
            overflow <= 1'b0;
        else if (ovfl_clr)
            overflow <= ovfl_pulse;
        else
            overflow <= overflow | ovfl_pulse;
    end

endmodule

//--- rtl/cpu_cycle_counters.sv
/* cpu cycle counters
   ctr0 counts every cycle, ctr1 only while enabled, both cleared by event */
`timescale 1ns/1ps
`include "kiwi_defines.svh"

module cpu_cycle_counters
    import kiwi_pkg::*;
(
    input  logic cpu_clk,
    input  logic rx_orst,
    // cpu event bus
    input  op_t  op,
    input  logic wr_evt,
    // accumulators
    output ctr_t ctr0,
    output ctr_t ctr1
);

    // event decode
    logic ctr_clr;
    logic ctr_ena;
    logic ctr_dis;
    // gate for ctr1
    logic ena;

    assign ctr_clr = wr_evt & op[`KIWI_OP_CPU_CTR_CLR];
    assign ctr_ena = wr_evt & op[`KIWI_OP_CPU_CTR_ENA];
    assign ctr_dis = wr_evt & op[`KIWI_OP_CPU_CTR_DIS];

    // enable takes effect on the event edge, disable wins a tie
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
            ena <= 1'b0;
        else if (ctr_dis)
            ena <= 1'b0;
        else if (ctr_ena)
            ena <= 1'b1;
    end

    //////////////////////////////////////////////////////////////////////
    // accumulators
    //////////////////////////////////////////////////////////////////////

    // clear lands both counters on zero at the event edge
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst || ctr_clr)
        begin
            ctr0 <= '0;
            ctr1 <= '0;
        end
        else
        begin
            ctr0 <= ctr0 + 32'd1;
            ctr1 <= ctr1 + {31'd0, ena};
        end
    end

endmodule

//--- rtl/cpu_read_port.sv
/* cpu read port
   parallel input mux with status word, and host service request capture */
`timescale 1ns/1ps
`include "kiwi_defines.svh"

module cpu_read_port
    import kiwi_pkg::*;
(
    input  logic  cpu_clk,
    input  logic  rx_orst,
    // cpu read bus
    input  op_t   op,
    input  logic  rd_reg,
    // status and counter sources
    input  logic  overflow,
    input  ctr_t  ctr0,
    input  ctr_t  ctr1,
    // host side
    input  word_t host_dout,
    input  logic  host_srq,
    // cpu inputs
    output word_t par,
    output logic  ser
);

    // read decode
    logic  get_srq;
    // request seen since the last GET_SRQ
    logic  srq_pend;
    word_t status;

    assign get_srq = rd_reg & op[`KIWI_OP_GET_SRQ];

    // ovfl, srq pending, version, zero nibble, board id
    assign status = {overflow, srq_pend, `KIWI_FPGA_VER, 4'b0000, `KIWI_FPGA_ID};

    //////////////////////////////////////////////////////////////////////
    // parallel input mux
    //////////////////////////////////////////////////////////////////////

    // counter bytes first, then status, host data otherwise
    // each counter read pairs ctr1 byte high with ctr0 byte low
    always_comb
    begin
        if (rd_reg && op[`KIWI_OP_GET_CPU_CTR0])
            par = {ctr1[7:0], ctr0[7:0]};
        else if (rd_reg && op[`KIWI_OP_GET_CPU_CTR1])
            par = {ctr1[15:8], ctr0[15:8]};
        else if (rd_reg && op[`KIWI_OP_GET_CPU_CTR2])
            par = {ctr1[23:16], ctr0[23:16]};
        else if (rd_reg && op[`KIWI_OP_GET_CPU_CTR3])
            par = {ctr1[31:24], ctr0[31:24]};
        else if (rd_reg && op[`KIWI_OP_GET_STATUS])
            par = status;
        else
            par = host_dout;
    end

    //////////////////////////////////////////////////////////////////////
    // service request capture
    //////////////////////////////////////////////////////////////////////

    // a read hands the pending flag to ser
    // a pulse in the read cycle itself is kept for the next read
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
        begin
            srq_pend <= 1'b0;
            ser      <= 1'b0;
        end
        else if (get_srq)
        begin
            srq_pend <= host_srq;
            ser      <= srq_pend;
        end
        else
        begin
            srq_pend <= srq_pend | host_srq;
        end
    end

endmodule

//--- rtl/ctrl_reg.sv
/* global control register
   loaded from the cpu bus, fields drive the board control pins */
`timescale 1ns/1ps
`include "kiwi_defines.svh"

module ctrl_reg
    import kiwi_pkg::*;
(
    input  logic  cpu_clk,
    input  logic  rx_orst,
    // cpu register bus
    input  op_t   op,
    input  tos_t  tos,
    input  logic  wr_reg,
    // register value and the pins it drives
    output ctrl_t ctrl,
    output logic  adc_clken,
    output logic  ewp,
    output logic  cmd_ready,
    output logic  snd_intr
);

    // write decode
    logic set_ctrl;

    assign set_ctrl = wr_reg & op[`KIWI_OP_SET_CTRL];

    //////////////////////////////////////////////////////////////////////
    // control register
    //////////////////////////////////////////////////////////////////////

    // only the low word of tos is meaningful here
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
        begin
            ctrl <= '0;
        end
        else if (set_ctrl)
        begin
            ctrl <= ctrl_t'(tos[15:0]);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // pin outputs
    //////////////////////////////////////////////////////////////////////

    // oscillator enable goes straight to the adc clock enable pin
    assign adc_clken = ctrl.osc_en;
    assign ewp       = ctrl.eeprom_wp;
    assign cmd_ready = ctrl.cmd_ready;
    // single interrupt source in this build
    assign snd_intr  = ctrl.snd_intr;

endmodule

//--- rtl/kiwi_ctrl_top.sv
/* receiver control and status hub
   joins control register, overflow monitor, cycle counters and cpu read port */
`timescale 1ns/1ps
`include "kiwi_defines.svh"

module kiwi_ctrl_top
    import kiwi_pkg::*;
(
    input  logic  cpu_clk,
    input  logic  rx_orst,
    // cpu register bus
    input  op_t   op,
    input  tos_t  tos,
    input  logic  wr_reg,
    input  logic  wr_evt,
    input  logic  rd_reg,
    // receiver and host side
    input  logic  adc_ovfl,
    input  logic  host_srq,
    input  word_t host_dout,
    // cpu inputs
    output word_t par,
    output logic  ser,
    // board pins
    output logic  adc_clken,
    output logic  ewp,
    output logic  cmd_ready,
    output logic  snd_intr
);

    // sticky overflow into status
    logic overflow;
    // cycle counters into the read mux
    ctr_t ctr0;
    ctr_t ctr1;

    //////////////////////////////////////////////////////////////////////
    // control register
    //////////////////////////////////////////////////////////////////////

    // register value only feeds the pins at this level
    ctrl_reg u_ctrl_reg (
        .cpu_clk   (cpu_clk),
        .rx_orst   (rx_orst),
        .op        (op),
        .tos       (tos),
        .wr_reg    (wr_reg),
        .ctrl      (),
        .adc_clken (adc_clken),
        .ewp       (ewp),
        .cmd_ready (cmd_ready),
        .snd_intr  (snd_intr)
    );

    adc_ovfl_monitor #(
        .win_bits (`KIWI_OVFL_WIN_BITS)
    ) u_adc_ovfl_monitor (
        .cpu_clk  (cpu_clk),
        .rx_orst  (rx_orst),
        .op       (op),
        .tos      (tos),
        .wr_reg   (wr_reg),
        .wr_evt   (wr_evt),
        .adc_ovfl (adc_ovfl),
        .overflow (overflow)
    );

    //////////////////////////////////////////////////////////////////////
    // counters and read side
    //////////////////////////////////////////////////////////////////////

    cpu_cycle_counters u_cpu_cycle_counters (
        .cpu_clk (cpu_clk),
        .rx_orst (rx_orst),
        .op      (op),
        .wr_evt  (wr_evt),
        .ctr0    (ctr0),
        .ctr1    (ctr1)
    );

    cpu_read_port u_cpu_read_port (
        .cpu_clk   (cpu_clk),
        .rx_orst   (rx_orst),
        .op        (op),
        .rd_reg    (rd_reg),
        .overflow  (overflow),
        .ctr0      (ctr0),
        .ctr1      (ctr1),
        .host_dout (host_dout),
        .host_srq  (host_srq),
        .par       (par),
        .ser       (ser)
    );

endmodule

//--- rtl/kiwi_defines.svh
/* receiver control hub constants
   cpu opcode bit positions, overflow window size, version and board id */
`ifndef KIWI_DEFINES_SVH
`define KIWI_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// one-hot opcode bit positions
//////////////////////////////////////////////////////////////////////

// register writes, qualified by wr_reg
`define KIWI_OP_SET_CTRL        0
`define KIWI_OP_SET_CNT_MASK    1

// register reads, qualified by rd_reg
`define KIWI_OP_GET_STATUS      2
`define KIWI_OP_GET_SRQ         3
`define KIWI_OP_GET_CPU_CTR0    4
`define KIWI_OP_GET_CPU_CTR1    5
`define KIWI_OP_GET_CPU_CTR2    6
`define KIWI_OP_GET_CPU_CTR3    7

// events, qualified by wr_evt
`define KIWI_OP_CPU_CTR_CLR     8
`define KIWI_OP_CPU_CTR_ENA     9
`define KIWI_OP_CPU_CTR_DIS     10
`define KIWI_OP_OVFL_CLR        11

//////////////////////////////////////////////////////////////////////
// overflow monitor
//////////////////////////////////////////////////////////////////////

// log2 of window length in cpu_clk cycles
// short window keeps simulation quick, board build ran 16
`define KIWI_OVFL_WIN_BITS      6

//////////////////////////////////////////////////////////////////////
// identification fields reported in the status word
//////////////////////////////////////////////////////////////////////

`define KIWI_FPGA_VER           6'd1
`define KIWI_FPGA_ID            4'd2

`endif

//--- rtl/kiwi_pkg.sv
/* shared types for the receiver control hub */
package kiwi_pkg;

    // parallel port word seen by the cpu
    typedef logic [15:0] word_t;

    // one-hot opcode from the cpu decoder
    typedef logic [15:0] op_t;

    // top of stack, two words wide
    typedef logic [31:0] tos_t;

    // cycle counter accumulator
    typedef logic [31:0] ctr_t;

    // global control register layout
    // first field is the msb, spares fill the low bits
    typedef struct packed {
        // adc oscillator enable
        logic        osc_en;
        // eeprom write protect
        logic        eeprom_wp;
        // tell the host a command is waiting
        logic        cmd_ready;
        // audio interrupt to the host
        logic        snd_intr;
        // unassigned, still readable and writable
        logic [11:0] spare;
    } ctrl_t;

endpackage

//--- sim.f
+incdir+rtl
rtl/kiwi_pkg.sv
rtl/ctrl_reg.sv
rtl/adc_ovfl_monitor.sv
rtl/cpu_cycle_counters.sv
rtl/cpu_read_port.sv
rtl/kiwi_ctrl_top.sv
dv/kiwi_ctrl_tb.sv
